// ==== vlog.f ====
hdl/analog_pkg.sv
hdl/analog_bus_if.sv
hdl/adc_frontend.sv
hdl/dac_backend.sv
hdl/adc_calibrator.sv
hdl/analog_io_top.sv
tests/tb_analog_io.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the analog data path testbench with verilator, run it, grep the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=sim_tb_analog_io

verilator --binary --timing --assert -f vlog.f --top-module tb_analog_io \
  -Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./"$OBJ"/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

if grep -q "^RESULT: PASS$" "$LOG"; then
  echo "simulation passed, see $LOG"
  exit 0
else
  echo "simulation failed, see $LOG"
  exit 1
fi

// ==== tests/tb_analog_io.sv ====
// testbench for analog_io_top with seeded random stimulus, reference model, checks and timeout
`timescale 1ns/100ps
`default_nettype none

module tb_analog_io;
  import analog_pkg::*;

  localparam int N_RUN       = 500;   // cycles per main test phase
  localparam int N_RESUME    = 350;   // cycles per phase after mid-run reset
  localparam int TIMEOUT_CYC = 3000;  // tests need about 2200 cycles
  localparam int M_IDLE = 0;          // hold inputs, loopback off
  localparam int M_ADC  = 1;          // random raw words
  localparam int M_DAC  = 2;          // random raw plus large asg/pid
  localparam int M_LOOP = 3;          // loopback on

  logic      adc_clk;
  logic      rst_i;
  logic      digital_loop_i;
  raw_t      raw_drv [N_CH];          // driven adc words
  sample_t   asg_drv [N_CH];
  sample_t   pid_drv [N_CH];
  raw_t      adc_dat_a_i, adc_dat_b_i;
  sample_t   asg_a_i, asg_b_i, pid_a_i, pid_b_i;
  sample_t   adc_a_o, adc_b_o, cal_a_o, cal_b_o;
  dac_code_t dac_dat_a_o, dac_dat_b_o;
  sample_t   adc_out [N_CH];
  sample_t   cal_out [N_CH];
  dac_code_t dac_out [N_CH];

  // reference model state
  logic [SAMPLE_W-1:0] raw_m  [N_CH];                 // registered raw bits
  dac_code_t           dac_m  [N_CH];
  sample_t             pipe_m [N_CH][CAL_LATENCY-1];  // resync delay line
  sample_t             cal_m  [N_CH];
  int                  seed = 32'h2f56;
  int                  cycle_cnt = 0;
  int                  n_sat_hi = 0;   // clipped at the top
  int                  n_sat_lo = 0;   // clipped at the bottom

  assign adc_dat_a_i = raw_drv[0];
  assign adc_dat_b_i = raw_drv[1];
  assign asg_a_i = asg_drv[0];
  assign asg_b_i = asg_drv[1];
  assign pid_a_i = pid_drv[0];
  assign pid_b_i = pid_drv[1];
  assign adc_out[0] = adc_a_o;
  assign adc_out[1] = adc_b_o;
  assign cal_out[0] = cal_a_o;
  assign cal_out[1] = cal_b_o;
  assign dac_out[0] = dac_dat_a_o;
  assign dac_out[1] = dac_dat_b_o;

  analog_io_top u_dut (
    .adc_clk        (adc_clk       ),
    .rst_i          (rst_i         ),
    .adc_dat_a_i    (adc_dat_a_i   ),
    .adc_dat_b_i    (adc_dat_b_i   ),
    .asg_a_i        (asg_a_i       ),
    .asg_b_i        (asg_b_i       ),
    .pid_a_i        (pid_a_i       ),
    .pid_b_i        (pid_b_i       ),
    .digital_loop_i (digital_loop_i),
    .adc_a_o        (adc_a_o       ),
    .adc_b_o        (adc_b_o       ),
    .cal_a_o        (cal_a_o       ),
    .cal_b_o        (cal_b_o       ),
    .dac_dat_a_o    (dac_dat_a_o   ),
    .dac_dat_b_o    (dac_dat_b_o   )
  );

  initial
  begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;  // 10 ns period
  end

  always @(posedge adc_clk)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC)
    begin
      $display("timeout: %0d cycles passed and the tests did not finish", cycle_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "run stopped by timeout");
    end
  end

  //////////////////////////////////////////////////
  // model functions
  //////////////////////////////////////////////////

  // keep msb, invert the 13 lower bits
  function automatic logic [SAMPLE_W-1:0] flip_low(input logic [SAMPLE_W-1:0] x);
    return x ^ SAMPLE_W'((1 << (SAMPLE_W-1)) - 1);
  endfunction

  // clip the true sum into the 14 bit range
  function automatic sample_t sat_sum(input sample_t a, input sample_t b);
    int s;
    int hi;
    int lo;
    s  = int'(a) + int'(b);
    hi = (1 << (SAMPLE_W-1)) - 1;
    lo = -(1 << (SAMPLE_W-1));
    if (s > hi)
      s = hi;
    else if (s < lo)
      s = lo;
    return sample_t'(s);
  endfunction

  // offset, gain, slice and bias on the unsigned view of the sample
  function automatic sample_t cal_rule(input sample_t x);
    longint v;
    v = longint'({1'b0, x});                              // zero extended
    v = (v - CAL_OFFSET) & ((64'sd1 << CAL_PROD_W) - 1);
    v = (v * CAL_GAIN) & ((64'sd1 << CAL_PROD_W) - 1);
    v = (v >> CAL_SLICE_LO) & ((64'sd1 << (CAL_SLICE_HI - CAL_SLICE_LO + 1)) - 1);
    v = (v - CAL_BIAS) & ((64'sd1 << SAMPLE_W) - 1);      // wraps at 14 bits
    return sample_t'(v);
  endfunction

  // adc output of the current cycle, loopback is same cycle
  function automatic sample_t adc_expect(input int ch);
    if (digital_loop_i)
      return sat_sum(asg_drv[ch], pid_drv[ch]);
    return sample_t'(flip_low(raw_m[ch]));
  endfunction

  // mostly large magnitudes so sums clip both ways
  function automatic sample_t rand_big();
    logic [31:0] r;
    r = $random(seed);
    case (r[31:30])
      2'd2:    return {2'b01, r[11:0]};  // 4096 and up
      2'd3:    return {2'b10, r[11:0]};  // -4097 and down
      default: return r[SAMPLE_W-1:0];
    endcase
  endfunction

  //////////////////////////////////////////////////
  // cycle tasks
  //////////////////////////////////////////////////

  task automatic check_val(input string name, input logic [SAMPLE_W-1:0] exp_v,
                           input logic [SAMPLE_W-1:0] act_v);
    if (exp_v !== act_v)
    begin
      $display("mismatch %s: expected %h, got %h at cycle %0d", name, exp_v, act_v, cycle_cnt);
      $display("RESULT: FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // advance the model by one clock edge
  task automatic update_model();
    int s;
    for (int ch = 0; ch < N_CH; ch++)
    begin
      if (rst_i)
      begin
        raw_m[ch] = '0;
        dac_m[ch] = '0;
        cal_m[ch] = '0;
        for (int k = 0; k < CAL_LATENCY-1; k++)
          pipe_m[ch][k] = '0;  // queues restart from zero
      end
      else
      begin
        cal_m[ch] = cal_rule(pipe_m[ch][CAL_LATENCY-2]);
        for (int k = CAL_LATENCY-2; k > 0; k--)
          pipe_m[ch][k] = pipe_m[ch][k-1];
        pipe_m[ch][0] = adc_expect(ch);  // before raw_m moves on
        s = int'(asg_drv[ch]) + int'(pid_drv[ch]);
        if (s >= (1 << (SAMPLE_W-1)))
          n_sat_hi++;
        if (s < -(1 << (SAMPLE_W-1)))
          n_sat_lo++;
        dac_m[ch] = flip_low(sat_sum(asg_drv[ch], pid_drv[ch]));
        raw_m[ch] = raw_drv[ch][ADC_RAW_W-1:ADC_PAD_W];
      end
    end
  endtask

  // edge, model step, drive 1 ns later, compare at the falling edge
  task automatic run_cycle(input int mode, input logic rst_v);
    @(posedge adc_clk);
    update_model();
    #1;
    rst_i          = rst_v;
    digital_loop_i = (mode == M_LOOP);
    for (int ch = 0; ch < N_CH; ch++)
    begin
      if (mode != M_IDLE)
        raw_drv[ch] = raw_t'($random(seed));
      if (mode == M_DAC || mode == M_LOOP)
      begin
        asg_drv[ch] = rand_big();
        pid_drv[ch] = rand_big();
      end
    end
    @(negedge adc_clk);
    for (int ch = 0; ch < N_CH; ch++)
    begin
      check_val($sformatf("adc_%s_o", (ch == 0) ? "a" : "b"), adc_expect(ch), adc_out[ch]);
      check_val($sformatf("cal_%s_o", (ch == 0) ? "a" : "b"), cal_m[ch], cal_out[ch]);
      check_val($sformatf("dac_dat_%s_o", (ch == 0) ? "a" : "b"), dac_m[ch], dac_out[ch]);
    end
  endtask

  // fixed values right after a reset
  task automatic check_reset_values();
    check_val("adc_a_o", 14'h1fff, adc_a_o);
    check_val("adc_b_o", 14'h1fff, adc_b_o);
    check_val("cal_a_o", '0, cal_a_o);
    check_val("cal_b_o", '0, cal_b_o);
    check_val("dac_dat_a_o", '0, dac_dat_a_o);
    check_val("dac_dat_b_o", '0, dac_dat_b_o);
  endtask

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial
  begin
    rst_i          = 1'b1;  // covers the first edge
    digital_loop_i = 1'b0;
    for (int ch = 0; ch < N_CH; ch++)
    begin
      raw_drv[ch] = '0;
      asg_drv[ch] = '0;
      pid_drv[ch] = '0;
    end
    run_cycle(M_IDLE, 1'b1);
    run_cycle(M_IDLE, 1'b0);  // second reset edge, then release
    check_reset_values();
    repeat (N_RUN) run_cycle(M_ADC, 1'b0);   // conversion + calibration
    repeat (N_RUN) run_cycle(M_DAC, 1'b0);   // sum and clipping
    repeat (N_RUN) run_cycle(M_LOOP, 1'b0);  // digital loopback
    run_cycle(M_IDLE, 1'b1);                 // mid-run reset, 2 edges
    run_cycle(M_IDLE, 1'b1);
    run_cycle(M_IDLE, 1'b0);
    check_reset_values();
    repeat (N_RESUME) run_cycle(M_ADC, 1'b0);
    repeat (N_RESUME) run_cycle(M_LOOP, 1'b0);
    if (n_sat_hi == 0 || n_sat_lo == 0)
    begin
      $display("dac sum never clipped in both directions (hi %0d, lo %0d)", n_sat_hi, n_sat_lo);
      $display("RESULT: FAIL");
      $fatal(1, "saturation not exercised");
    end
    else
    begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule : tb_analog_io

`default_nettype wire

// ==== hdl/analog_io_top.sv ====
// top level joining adc front end, dac back end and calibrator over the analog bus
`timescale 1ns/100ps
`default_nettype none

module analog_io_top (
  input  logic                  adc_clk,
  input  logic                  rst_i,           // sync, active high
  // adc pins
  input  analog_pkg::raw_t      adc_dat_a_i,
  input  analog_pkg::raw_t      adc_dat_b_i,
  // generator and controller samples
  input  analog_pkg::sample_t   asg_a_i,
  input  analog_pkg::sample_t   asg_b_i,
  input  analog_pkg::sample_t   pid_a_i,
  input  analog_pkg::sample_t   pid_b_i,
  input  logic                  digital_loop_i,  // dac into adc path
  // converted adc
  output analog_pkg::sample_t   adc_a_o,
  output analog_pkg::sample_t   adc_b_o,
  // calibrated adc
  output analog_pkg::sample_t   cal_a_o,
  output analog_pkg::sample_t   cal_b_o,
  // dac pins
  output analog_pkg::dac_code_t dac_dat_a_o,
  output analog_pkg::dac_code_t dac_dat_b_o
);

  //////////////////////////////////////////////////
  // sample bus between the blocks
  //////////////////////////////////////////////////

  analog_bus_if u_bus ();

  //////////////////////////////////////////////////
  // adc in
  //////////////////////////////////////////////////

  adc_frontend u_frontend (
    .adc_clk        (adc_clk       ),
    .rst_i          (rst_i         ),
    .adc_dat_a_i    (adc_dat_a_i   ),
    .adc_dat_b_i    (adc_dat_b_i   ),
    .digital_loop_i (digital_loop_i),
    .bus            (u_bus         ),  // drives adc, reads dac
    .adc_a_o        (adc_a_o       ),
    .adc_b_o        (adc_b_o       )
  );

  //////////////////////////////////////////////////
  // dac out
  //////////////////////////////////////////////////

  dac_backend u_backend (
    .adc_clk        (adc_clk       ),
    .rst_i          (rst_i         ),
    .asg_a_i        (asg_a_i       ),
    .asg_b_i        (asg_b_i       ),
    .pid_a_i        (pid_a_i       ),
    .pid_b_i        (pid_b_i       ),
    .bus            (u_bus         ),  // drives dac
    .dac_dat_a_o    (dac_dat_a_o   ),
    .dac_dat_b_o    (dac_dat_b_o   )
  );

  //////////////////////////////////////////////////
  // calibration
  //////////////////////////////////////////////////

  adc_calibrator u_calib (
    .adc_clk        (adc_clk       ),
    .rst_i          (rst_i         ),
    .bus            (u_bus         ),  // reads adc
    .cal_a_o        (cal_a_o       ),
    .cal_b_o        (cal_b_o       )
  );

endmodule : analog_io_top

`default_nettype wire

// ==== hdl/adc_calibrator.sv ====
// adc calibration with two stage resync and fixed point offset, gain and bias
`timescale 1ns/100ps
`default_nettype none

module adc_calibrator (
  input  logic                adc_clk,
  input  logic                rst_i,
  // converted adc samples
  analog_bus_if.calib         bus,
  // calibrated samples
  output analog_pkg::sample_t cal_a_o,
  output analog_pkg::sample_t cal_b_o
);
  import analog_pkg::*;

  sample_t adc_in [N_CH];
  sample_t cal    [N_CH];

  assign adc_in[0] = bus.adc_a;
  assign adc_in[1] = bus.adc_b;

  //////////////////////////////////////////////////
  // per channel pipeline
  //////////////////////////////////////////////////

  for (genvar ch = 0; ch < N_CH; ch++)
  begin : g_ch
    // resync chain, last stage feeds the arithmetic
    logic [SAMPLE_W-1:0]                  sync_q [CAL_LATENCY-1];
    logic [CAL_PROD_W-1:0]                diff;   // sample - offset
    logic [CAL_PROD_W-1:0]                prod;   // diff * gain
    logic [CAL_SLICE_HI-CAL_SLICE_LO:0]   slice;  // 13 bit unsigned
    logic [SAMPLE_W-1:0]                  cal_d;
    sample_t                              cal_q;

    always_ff @(posedge adc_clk)
    begin
      if (rst_i)
      begin
        for (int s = 0; s < CAL_LATENCY-1; s++)
          sync_q[s] <= '0;
        cal_q <= '0;
      end
      else
      begin
        sync_q[0] <= adc_in[ch];  // taken as unsigned from here on
        for (int s = 1; s < CAL_LATENCY-1; s++)
          sync_q[s] <= sync_q[s-1];
        cal_q <= cal_d;
      end
    end

    // everything wraps at CAL_PROD_W bits
    assign diff  = CAL_PROD_W'(sync_q[CAL_LATENCY-2]) - CAL_PROD_W'(CAL_OFFSET);
    assign prod  = diff * CAL_PROD_W'(CAL_GAIN);
    assign slice = prod[CAL_SLICE_HI:CAL_SLICE_LO];
    // bias removal wraps at 14 bits
    assign cal_d = {1'b0, slice} - SAMPLE_W'(CAL_BIAS);

    assign cal[ch] = cal_q;
  end

  assign cal_a_o = cal[0];
  assign cal_b_o = cal[1];

  // whole chain flushed by one reset cycle
  a_cal_rst: assert property (@(posedge adc_clk)
    $past(rst_i) |-> ((cal_a_o == '0) && (cal_b_o == '0)));

endmodule : adc_calibrator

`default_nettype wire

// ==== hdl/dac_backend.sv ====
// dac back end with asg + pid sum, 14 bit saturation and registered dac code
`timescale 1ns/100ps
`default_nettype none

module dac_backend (
  input  logic                  adc_clk,
  input  logic                  rst_i,
  // generator and controller samples
  input  analog_pkg::sample_t   asg_a_i,
  input  analog_pkg::sample_t   asg_b_i,
  input  analog_pkg::sample_t   pid_a_i,
  input  analog_pkg::sample_t   pid_b_i,
  // internal bus
  analog_bus_if.backend         bus,
  // dac pins, offset binary
  output analog_pkg::dac_code_t dac_dat_a_o,
  output analog_pkg::dac_code_t dac_dat_b_o
);
  import analog_pkg::*;

  sample_t          asg   [N_CH];
  sample_t          pid   [N_CH];
  logic [SUM_W-1:0] sum   [N_CH];  // one guard bit above the sample
  sample_t          sat   [N_CH];  // clipped to 14 bits
  dac_code_t        dac_q [N_CH];  // output regs

  assign asg[0] = asg_a_i;
  assign asg[1] = asg_b_i;
  assign pid[0] = pid_a_i;
  assign pid[1] = pid_b_i;

  //////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////

  always_comb
  begin
    for (int ch = 0; ch < N_CH; ch++)
    begin
      // sign extend both, then add
      sum[ch] = {asg[ch][SAMPLE_W-1], asg[ch]} + {pid[ch][SAMPLE_W-1], pid[ch]};
      // top two bits disagree means overflow
      if (^sum[ch][SUM_W-1:SUM_W-2])
        sat[ch] = {sum[ch][SUM_W-1], {(SAMPLE_W-1){~sum[ch][SUM_W-1]}}};  // clip
      else
        sat[ch] = sum[ch][SAMPLE_W-1:0];
    end
  end

  assign bus.dac_a = sat[0];  // loopback source
  assign bus.dac_b = sat[1];

  //////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////

  // signed to offset binary with negative slope
  always_ff @(posedge adc_clk)
  begin
    for (int ch = 0; ch < N_CH; ch++)
    begin
      if (rst_i)
        dac_q[ch] <= '0;
      else
        dac_q[ch] <= {sat[ch][SAMPLE_W-1], ~sat[ch][SAMPLE_W-2:0]};
    end
  end

  assign dac_dat_a_o = dac_q[0];
  assign dac_dat_b_o = dac_q[1];

  // clipping never flips the sign seen at the dac pins
  for (genvar ch = 0; ch < N_CH; ch++)
  begin : g_sign_chk
    a_dac_sign: assert property (@(posedge adc_clk) disable iff (rst_i)
      !$past(rst_i) |-> (dac_q[ch][SAMPLE_W-1] == $past(sum[ch][SUM_W-1])));
  end

endmodule : dac_backend

`default_nettype wire

// ==== hdl/adc_frontend.sv ====
// adc front end with input regs, neg slope conversion and digital loopback mux
`timescale 1ns/100ps
`default_nettype none

module adc_frontend (
  input  logic                  adc_clk,
  input  logic                  rst_i,
  // adc pins
  input  analog_pkg::raw_t      adc_dat_a_i,
  input  analog_pkg::raw_t      adc_dat_b_i,
  input  logic                  digital_loop_i,  // 1 = feed dac back to adc
  // internal bus
  analog_bus_if.frontend        bus,
  // converted samples
  output analog_pkg::sample_t   adc_a_o,
  output analog_pkg::sample_t   adc_b_o
);
  import analog_pkg::*;

  //////////////////////////////////////////////////
  // input registers
  //////////////////////////////////////////////////

  raw_t                raw_in [N_CH];  // pins as an array
  logic [SAMPLE_W-1:0] raw_q  [N_CH];  // upper 14 bits, registered
  sample_t             conv   [N_CH];  // two's complement
  sample_t             loop   [N_CH];  // dac samples for loopback
  sample_t             adc    [N_CH];  // selected result

  assign raw_in[0] = adc_dat_a_i;
  assign raw_in[1] = adc_dat_b_i;

  // reserved lsbs dropped here
  always_ff @(posedge adc_clk)
  begin
    for (int ch = 0; ch < N_CH; ch++)
    begin
      if (rst_i)
        raw_q[ch] <= '0;  // converts to 14'h1fff
      else
        raw_q[ch] <= raw_in[ch][ADC_RAW_W-1:ADC_PAD_W];
    end
  end

  //////////////////////////////////////////////////
  // conversion and loopback
  //////////////////////////////////////////////////

  assign loop[0] = bus.dac_a;
  assign loop[1] = bus.dac_b;

  // adc code has a negative slope, so keep msb and flip the rest
  always_comb
  begin
    for (int ch = 0; ch < N_CH; ch++)
    begin
      conv[ch] = {raw_q[ch][SAMPLE_W-1], ~raw_q[ch][SAMPLE_W-2:0]};
      adc[ch]  = digital_loop_i ? loop[ch] : conv[ch];  // same cycle dac
    end
  end

  assign bus.adc_a = adc[0];
  assign bus.adc_b = adc[1];
  assign adc_a_o   = adc[0];
  assign adc_b_o   = adc[1];

  // outputs settle once reset is gone, loopback path included
  a_adc_known: assert property (@(posedge adc_clk) disable iff (rst_i)
    !$isunknown({adc_a_o, adc_b_o}));

endmodule : adc_frontend

`default_nettype wire

// ==== hdl/analog_bus_if.sv ====
// interface carrying converted adc and saturated dac samples, with modports
`timescale 1ns/100ps
`default_nettype none

interface analog_bus_if;
  import analog_pkg::*;

  // one new sample every adc_clk cycle, no handshake
  sample_t adc_a;  // converted adc, or dac in loopback
  sample_t adc_b;
  sample_t dac_a;  // saturated asg + pid sum
  sample_t dac_b;

  // front end drives adc and needs dac for loopback
  modport frontend (
    output adc_a, adc_b,
    input  dac_a, dac_b
  );

  // back end only produces the dac samples
  modport backend (
    output dac_a, dac_b
  );

  // calibrator only listens to adc
  modport calib (
    input  adc_a, adc_b
  );

endinterface : analog_bus_if

`default_nettype wire

// ==== hdl/analog_pkg.sv ====
// sample types, data path widths and adc calibration constants
`default_nettype none

package analog_pkg;

  //////////////////////////////////////////////////
  // data path widths
  //////////////////////////////////////////////////

  localparam int N_CH      = 2;   // channel a and b
  localparam int ADC_RAW_W = 16;  // word from the adc pins
  localparam int ADC_PAD_W = 2;   // reserved lsbs of the 16 bit adc
  localparam int SAMPLE_W  = 14;  // converted sample
  localparam int SUM_W     = 15;  // asg + pid, one guard bit

  //////////////////////////////////////////////////
  // calibration constants
  //////////////////////////////////////////////////

  // all arithmetic wraps modulo 2^CAL_PROD_W
  localparam int CAL_OFFSET   = 6690;  // removed before the gain
  localparam int CAL_GAIN     = 174;   // fixed gain, 8 bit value
  localparam int CAL_PROD_W   = 22;    // width of offset and product
  localparam int CAL_SLICE_HI = 18;    // top product bit kept
  localparam int CAL_SLICE_LO = 6;     // bottom product bit kept
  localparam int CAL_BIAS     = 4096;  // removed after slicing

  // two resync regs plus the output reg
  localparam int CAL_LATENCY  = 3;

  //////////////////////////////////////////////////
  // sample types
  //////////////////////////////////////////////////

  typedef logic        [ADC_RAW_W-1:0] raw_t;       // raw adc word, unsigned
  typedef logic signed [SAMPLE_W-1:0]  sample_t;    // two's complement sample
  typedef logic        [SAMPLE_W-1:0]  dac_code_t;  // offset binary, neg slope

endpackage : analog_pkg

`default_nettype wire
